/* logic/nocPkg.sv */
`default_nettype none

package nocPkg;

  // mesh router with one output port fed by five input channels.
  localparam int numPorts = 5;

  // channel index, which is also the priority order out of idle.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  localparam int lengthW = 12;

  // flit kinds.
  localparam logic [2:0] idHeader = 3'b001;
  localparam logic [2:0] idBody = 3'b010;
  localparam logic [2:0] idTail = 3'b100;

  // length is the tenure limit in flits.
  typedef struct packed {
    logic [2:0] flitId;
    logic spare;
    logic [lengthW-1:0] length;
  } headerFlit_t;

  typedef struct packed {
    logic [2:0] flitId;
    logic [12:0] payload;
  } bodyFlit_t;

  // one 16-bit word, read as a header or as a body flit.
  typedef union packed {
    headerFlit_t header;
    bodyFlit_t body;
  } flit_t;

  // forward half of a channel; ready runs back on its own wire.
  typedef struct packed {
    logic valid;
    flit_t flit;
  } flitChan_t;

  // one-hot arbiter state: bit 0 is idle, bits 1 to 5 grant L to S.
  typedef logic [numPorts:0] grant_t;

  localparam grant_t grantIdle = grant_t'(1);

endpackage

`default_nettype wire

/* logic/flitFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module flitFifo
#(
  parameter int fifoDepth = 8
)
(
  input wire logic clk,
  input wire logic rst,
  input wire nocPkg::flitChan_t inChan,
  output logic ready,
  input wire logic pop,
  output nocPkg::flit_t head,
  output logic notEmpty
);

  localparam int ptrW = $clog2(fifoDepth);

  // one extra pointer bit tells full from empty.
  logic [ptrW:0] wrPtr;
  logic [ptrW:0] rdPtr;
  logic [ptrW:0] fill;
  logic full;
  logic write;

  nocPkg::flit_t mem [fifoDepth];

  assign full = (wrPtr[ptrW] != rdPtr[ptrW]) &&
                (wrPtr[ptrW-1:0] == rdPtr[ptrW-1:0]);
  assign notEmpty = (wrPtr != rdPtr);
  assign ready = !full;
  assign write = inChan.valid && ready;
  assign fill = wrPtr - rdPtr;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (write)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (write)
    begin
      mem[wrPtr[ptrW-1:0]] <= inChan.flit;
    end
  end

  // oldest flit, left in place until popped.
  assign head = mem[rdPtr[ptrW-1:0]];

  // the output stage only pops a channel that is requesting.
  popWhileEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty);

  // a write into a full buffer would push the fill past the depth.
  writeWhileFull: assert property (@(posedge clk) disable iff (rst)
    !fill[ptrW] || (fill[ptrW-1:0] == '0));

endmodule

`default_nettype wire

/* logic/packetTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module packetTimer
(
  input wire logic clk,
  input wire logic rst,
  input wire nocPkg::flit_t head,
  input wire logic sent,
  input wire logic newTenure,
  output logic timesUp
);

  logic [nocPkg::lengthW-1:0] count;
  logic [nocPkg::lengthW-1:0] limit;
  logic [nocPkg::lengthW-1:0] countNext;
  logic [nocPkg::lengthW-1:0] limitNext;
  logic isHeader;

  assign isHeader = (head.header.flitId == nocPkg::idHeader);

  // a header picks up its length as it leaves.
  assign limitNext = (sent && isHeader) ? head.header.length : limit;

  assign countNext = (newTenure ? '0 : count) + {{(nocPkg::lengthW-1){1'b0}}, sent};

  // looks at the count including this cycle's flit, so the registered
  // grant moves on right after the last allowed flit.
  assign timesUp = (limitNext != '0) && (countNext >= limitNext);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else
    begin
      count <= countNext;
      limit <= limitNext;
    end
  end

endmodule

`default_nettype wire

/* logic/portArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module portArbiter
(
  input wire logic clk,
  input wire logic rst,
  input wire logic [nocPkg::numPorts-1:0] req,
  input wire logic [nocPkg::numPorts-1:0] timesUp,
  output nocPkg::grant_t grant,
  output logic [nocPkg::numPorts-1:0] newTenure
);

  nocPkg::grant_t nextGrant;
  int curPort;

  function automatic nocPkg::grant_t portGrant(input int p);
    return nocPkg::grant_t'(1) << (p + 1);
  endfunction

  function automatic int wrapPort(input int p);
    return (p >= nocPkg::numPorts) ? p - nocPkg::numPorts : p;
  endfunction

  // index of the port holding the link.
  always_comb
  begin
    curPort = 0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i + 1])
      begin
        curPort = i;
      end
    end
  end

  always_comb
  begin
    nextGrant = nocPkg::grantIdle;
    if (grant == nocPkg::grantIdle)
    begin
      if (req[nocPkg::portL])
      begin
        nextGrant = portGrant(nocPkg::portL);
      end
      else if (req[nocPkg::portN])
      begin
        nextGrant = portGrant(nocPkg::portN);
      end
      else if (req[nocPkg::portE])
      begin
        nextGrant = portGrant(nocPkg::portE);
      end
      else if (req[nocPkg::portW])
      begin
        nextGrant = portGrant(nocPkg::portW);
      end
      else if (req[nocPkg::portS])
      begin
        nextGrant = portGrant(nocPkg::portS);
      end
    end
    else if (req[curPort] && !timesUp[curPort])
    begin
      nextGrant = grant;
    end
    else
    begin
      // walk backwards so the nearest requester after curPort wins.
      // the current port itself is skipped, it goes back through idle.
      for (int k = nocPkg::numPorts - 1; k > 0; k--)
      begin
        if (req[wrapPort(curPort + k)])
        begin
          nextGrant = portGrant(wrapPort(curPort + k));
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= nocPkg::grantIdle;
      newTenure <= '0;
    end
    else
    begin
      grant <= nextGrant;
      newTenure <= nextGrant[nocPkg::numPorts:1] & ~grant[nocPkg::numPorts:1];
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant));

endmodule

`default_nettype wire

/* logic/linkOutput.sv */
`timescale 1ns/1ns
`default_nettype none

module linkOutput
(
  input wire logic clk,
  input wire logic rst,
  input wire nocPkg::grant_t grant,
  input wire nocPkg::flit_t [nocPkg::numPorts-1:0] heads,
  input wire logic [nocPkg::numPorts-1:0] notEmpty,
  output nocPkg::flitChan_t outChan,
  input wire logic outReady,
  output logic [nocPkg::numPorts-1:0] sent
);

  logic outValid;
  nocPkg::flit_t outFlit;
  nocPkg::flit_t selFlit;
  logic canLoad;

  always_comb
  begin
    selFlit = heads[0];
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i + 1])
      begin
        selFlit = heads[i];
      end
    end
  end

  // register is free when empty or being drained this cycle.
  assign canLoad = !outValid || outReady;
  assign sent = canLoad ? (grant[nocPkg::numPorts:1] & notEmpty) : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (canLoad)
    begin
      outValid <= |sent;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|sent)
    begin
      outFlit <= selFlit;
    end
  end

  assign outChan.valid = outValid;
  assign outChan.flit = outFlit;

  holdUnderStall: assert property (@(posedge clk) disable iff (rst)
    (outChan.valid && !outReady) |=> $stable(outChan));

endmodule

`default_nettype wire

/* logic/routerOutputPort.sv */
`timescale 1ns/1ns
`default_nettype none

module routerOutputPort
#(
  parameter int fifoDepth = 8
)
(
  input wire logic clk,
  input wire logic rst,
  input wire nocPkg::flitChan_t [nocPkg::numPorts-1:0] inChan,
  output logic [nocPkg::numPorts-1:0] inReady,
  output nocPkg::flitChan_t outChan,
  input wire logic outReady
);

  nocPkg::flit_t [nocPkg::numPorts-1:0] heads;
  logic [nocPkg::numPorts-1:0] notEmpty;
  logic [nocPkg::numPorts-1:0] sent;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::numPorts-1:0] newTenure;
  nocPkg::grant_t grant;

  // one buffer and one tenure timer per input channel.
  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : chan
    flitFifo #(
      .fifoDepth(fifoDepth)
    ) i_flitFifo (
      .clk(clk),
      .rst(rst),
      .inChan(inChan[p]),
      .ready(inReady[p]),
      .pop(sent[p]),
      .head(heads[p]),
      .notEmpty(notEmpty[p])
    );

    packetTimer i_packetTimer (
      .clk(clk),
      .rst(rst),
      .head(heads[p]),
      .sent(sent[p]),
      .newTenure(newTenure[p]),
      .timesUp(timesUp[p])
    );
  end

  portArbiter i_portArbiter (
    .clk(clk),
    .rst(rst),
    .req(notEmpty),
    .timesUp(timesUp),
    .grant(grant),
    .newTenure(newTenure)
  );

  linkOutput i_linkOutput (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .heads(heads),
    .notEmpty(notEmpty),
    .outChan(outChan),
    .outReady(outReady),
    .sent(sent)
  );

endmodule

`default_nettype wire

/* tb/routerOutputPortTb.sv */
`timescale 1ns/1ns
`default_nettype none

module routerOutputPortTb;

  localparam int fifoDepth = 8;
  localparam int slots = 8;
  localparam int expBase = nocPkg::numPorts * slots;
  localparam int memWords = expBase + 24;
  localparam int numRuns = 2;

  logic clk;
  logic rst;
  nocPkg::flitChan_t [nocPkg::numPorts-1:0] inChan;
  logic [nocPkg::numPorts-1:0] inReady;
  nocPkg::flitChan_t outChan;
  logic outReady;

  logic [15:0] flitMem [0:memWords-1];
  int chanLen [nocPkg::numPorts];
  logic [15:0] predicted [$];
  int flitCount;
  int seedValue;
  bit loaded;

  routerOutputPort #(
    .fifoDepth(fifoDepth)
  ) i_routerOutputPort (
    .clk(clk),
    .rst(rst),
    .inChan(inChan),
    .inReady(inReady),
    .outChan(outChan),
    .outReady(outReady)
  );

  always #4 clk = ~clk;

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  // replays the arbitration and tenure rules over the queued flits.
  task automatic buildModel();
    int pos [nocPkg::numPorts];
    int limit [nocPkg::numPorts];
    int cur;
    int nxt;
    int cnt;
    int c;
    nocPkg::flit_t f;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      pos[p] = 0;
      limit[p] = 0;
    end
    predicted.delete();
    cur = -1;
    while (predicted.size() < flitCount)
    begin
      nxt = -1;
      // rotate past the current holder first.
      if (cur >= 0)
      begin
        for (int k = 1; k < nocPkg::numPorts; k++)
        begin
          c = (cur + k) % nocPkg::numPorts;
          if (nxt < 0 && pos[c] < chanLen[c])
            nxt = c;
        end
      end
      // idle picks in fixed L, N, E, W, S order.
      if (nxt < 0)
      begin
        for (int p = nocPkg::numPorts - 1; p >= 0; p--)
        begin
          if (pos[p] < chanLen[p])
            nxt = p;
        end
      end
      cur = nxt;
      cnt = 0;
      while (pos[cur] < chanLen[cur])
      begin
        f = flitMem[cur * slots + pos[cur]];
        if (f.header.flitId == nocPkg::idHeader)
          limit[cur] = int'(f.header.length);
        predicted.push_back(f);
        pos[cur]++;
        cnt++;
        if (limit[cur] != 0 && cnt >= limit[cur])
          break;
      end
    end
  endtask

  task automatic resetDut();
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkValue("reset valid", 32'd0, 32'(outChan.valid));
    checkValue("reset ready", 32'h1f, 32'(inReady));
  endtask

  // all channels are written side by side while the link is stalled.
  task automatic loadChannels(input string name);
    for (int i = 0; i < slots; i++)
    begin
      @(posedge clk);
      for (int c = 0; c < nocPkg::numPorts; c++)
      begin
        inChan[c].valid <= (i < chanLen[c]);
        inChan[c].flit <= flitMem[c * slots + i];
      end
    end
    @(posedge clk);
    for (int c = 0; c < nocPkg::numPorts; c++)
      inChan[c].valid <= 1'b0;
    repeat (3) @(posedge clk);
    // L already moved one flit into the output register.
    for (int c = 1; c < nocPkg::numPorts; c++)
      checkValue($sformatf("%s full %0d", name, c), 32'(chanLen[c] < fifoDepth),
                 32'(inReady[c]));
  endtask

  task automatic drainOutput(input string name, input bit stalls);
    int idx;
    bit holding;
    nocPkg::flit_t held;
    idx = 0;
    holding = 0;
    held = '0;
    while (idx < predicted.size())
    begin
      @(posedge clk);
      if (holding)
      begin
        checkValue({name, " hold valid"}, 32'd1, 32'(outChan.valid));
        checkValue({name, " hold flit"}, 32'(held), 32'(outChan.flit));
      end
      holding = 0;
      if (outChan.valid && outReady)
      begin
        checkValue($sformatf("%s flit %0d", name, idx), 32'(predicted[idx]),
                   32'(outChan.flit));
        idx++;
      end
      else if (outChan.valid)
      begin
        holding = 1;
        held = outChan.flit;
      end
      outReady <= stalls ? (($urandom % 4) != 0) : 1'b1;
    end
    outReady <= 1'b1;
    // nothing may follow the last expected flit.
    repeat (10)
    begin
      @(posedge clk);
      checkValue({name, " extra flit"}, 32'd0, 32'(outChan.valid));
    end
    outReady <= 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inChan = '0;
    outReady = 1'b0;
    loaded = 0;
    seedValue = $urandom(32'hb20c);
    $readmemh("tb/flitInput.mem", flitMem);
    flitCount = 0;
    for (int c = 0; c < nocPkg::numPorts; c++)
    begin
      chanLen[c] = 0;
      while (chanLen[c] < slots && flitMem[c * slots + chanLen[c]] != 16'h0)
        chanLen[c]++;
      flitCount += chanLen[c];
    end
    loaded = 1;
    buildModel();
    for (int i = 0; i < flitCount; i++)
      checkValue($sformatf("model order %0d", i), 32'(flitMem[expBase + i]),
                 32'(predicted[i]));

    resetDut();
    loadChannels("preload");
    drainOutput("preload", 1'b0);

    resetDut();
    loadChannels("stall");
    drainOutput("stall", 1'b1);

    $display("NO ERRORS");
    $finish;
  end

  initial
  begin
    int watchCycles;
    wait (loaded);
    watchCycles = numRuns * 50 * flitCount + 200;
    #(watchCycles * 8);
    $display("output stopped: the flits did not all leave before the time limit");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* nocRouter.f */
logic/nocPkg.sv
logic/flitFifo.sv
logic/packetTimer.sv
logic/portArbiter.sv
logic/linkOutput.sv
logic/routerOutputPort.sv
tb/routerOutputPortTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= routerOutputPortTb
FILELIST ?= nocRouter.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tb/flitInput.mem */
// rows 1-5: flits of channels L N E W S, eight words each, 0000 marks an unused slot
// rows 6-8: expected output flit order, 0000 pads the end
// body and tail payload: bits 10:8 source port, bits 7:0 sequence number
2003 4001 8002 0000 0000 0000 0000 0000
2002 4101 4102 8103 2004 4105 4106 8107
2005 4201 4202 8203 0000 0000 0000 0000
2001 8301 0000 0000 0000 0000 0000 0000
2002 4401 8402 0000 0000 0000 0000 0000
2003 4001 8002 2002 4101 2005 4201 4202
8203 2001 2002 4401 4102 8103 8301 8402
2004 4105 4106 8107 0000 0000 0000 0000
